// File: src/pkg/rv_isa_pkg.sv
package rv_isa_pkg;

  //////////////////////////////
  // architectural widths
  //////////////////////////////

  typedef logic [31:0] data_t;     // register value
  typedef logic [31:0] addr_t;     // byte address
  typedef logic [4:0]  reg_idx_t;  // x0..x31, x0 is hardwired zero
  typedef logic [2:0]  funct3_t;   // branch condition field

  // branch conditions carried in funct3
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  //////////////////////////////
  // operations
  //////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B                     // lui style, b straight through
  } alu_op_e;

  // bit 2 set means a divide or remainder
  typedef enum logic [2:0] {
    MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU,
    MD_DIV, MD_DIVU, MD_REM, MD_REMU
  } muldiv_op_e;

endpackage

// File: src/pkg/ex_pipe_pkg.sv
package ex_pipe_pkg;

  import rv_isa_pkg::*;

  //////////////////////////////
  // operand selection
  //////////////////////////////

  typedef enum logic [1:0] {
    FWD_REG,                       // value read in decode
    FWD_MEM,                       // result sitting in the memory stage
    FWD_WB                         // result being written back
  } fwd_sel_e;

  typedef enum logic {
    SRC_B_RS2,
    SRC_B_IMM
  } alu_src_b_e;

  typedef enum logic [1:0] {
    RES_ALU,
    RES_LOAD,
    RES_PC4                        // jal/jalr link value
  } result_src_e;

  //////////////////////////////
  // stage bundles
  //////////////////////////////

  typedef struct packed {
    logic        valid;
    addr_t       pc_cur;
    data_t       rd1;
    data_t       rd2;
    data_t       imm_ext;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    alu_op_e     alu_op;
    alu_src_b_e  alu_src_b;
    logic        is_muldiv;
    muldiv_op_e  md_op;
    logic        branch;
    logic        jump;             // jal and jalr both set this
    logic        jalr;
    funct3_t     funct3;
    logic        reg_write;
    result_src_e result_src;
  } id_to_ex_t;

  typedef struct packed {
    logic     reg_write;
    reg_idx_t rd;
    data_t    value;
  } fwd_src_t;

  typedef struct packed {
    logic        valid;
    logic        reg_write;
    result_src_e result_src;
    reg_idx_t    rd;
    data_t       result;
    addr_t       pc_cur;
  } ex_to_mem_t;

  typedef struct packed {
    logic  redirect;
    addr_t target;
  } ex_to_if_t;

  typedef struct packed {
    muldiv_op_e op;
    data_t      a;
    data_t      b;
  } md_req_t;

endpackage

// File: src/alu.sv
module alu
  ( input  rv_isa_pkg::data_t   a
  , input  rv_isa_pkg::data_t   b
  , input  rv_isa_pkg::alu_op_e op
  , output rv_isa_pkg::data_t   result
  , output logic                zero
  );

  import rv_isa_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];               // rv32 shifts only look at 5 bits
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  //////////////////////////////
  // operation select
  //////////////////////////////

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;            // beq/bne compare through zero
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      ALU_SLL:    result = a << shamt;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $signed(a) >>> shamt;
      ALU_SLT:    result = {31'd0, lt_signed};
      ALU_SLTU:   result = {31'd0, lt_unsigned};
      ALU_PASS_B: result = b;
      default:    result = '0;               // unused encodings
    endcase
  end

  // branch logic reads this together with result
  assign zero = (result == '0);

endmodule

// File: src/forward_unit.sv
module forward_unit
  ( input  rv_isa_pkg::reg_idx_t  rs1
  , input  rv_isa_pkg::reg_idx_t  rs2
  , input  ex_pipe_pkg::fwd_src_t mem_fwd
  , input  ex_pipe_pkg::fwd_src_t wb_fwd
  , output ex_pipe_pkg::fwd_sel_e fwd_a
  , output ex_pipe_pkg::fwd_sel_e fwd_b
  );

  import rv_isa_pkg::*;
  import ex_pipe_pkg::*;

  // a later stage can supply rs only if it writes a real register
  function automatic logic hits(fwd_src_t src, reg_idx_t rs);
    return src.reg_write && (src.rd != '0) && (src.rd == rs);
  endfunction

  // youngest result wins
  function automatic fwd_sel_e pick(reg_idx_t rs);
    fwd_sel_e sel;
    if (hits(mem_fwd, rs)) begin
      sel = FWD_MEM;
    end else if (hits(wb_fwd, rs)) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_REG;
    end
    return sel;
  endfunction

  always_comb begin
    fwd_a = pick(rs1);
    fwd_b = pick(rs2);
  end

endmodule

// File: src/step_counter.sv
module step_counter
  ( input  logic clk
  , input  logic rst_n
  , input  logic load
  , input  logic step
  , output logic last
  );

  logic [4:0] count;

  // 31 down to 0 gives 32 iterations
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= 5'd31;              // keeps last low out of reset
    end else if (load) begin
      count <= 5'd31;
    end else if (step) begin
      count <= count - 5'd1;       // wraps back to 31 after the final step
    end
  end

  assign last = (count == 5'd0);

endmodule

// File: src/muldiv_ctrl.sv
module muldiv_ctrl
  ( input  logic clk
  , input  logic rst_n
  , input  logic req
  , input  logic last
  , output logic ack
  , output logic load
  , output logic step
  , output logic finish
  );

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,                        // one iteration per cycle
    ST_FIX,                        // sign correction and word select
    ST_ACK                         // result valid, wait for req low
  } state_e;

  state_e state;
  state_e state_next;

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (req) begin
          state_next = ST_RUN;
        end
      end
      ST_RUN: begin
        if (last) begin
          state_next = ST_FIX;     // counter has paced all 32 steps
        end
      end
      ST_FIX: state_next = ST_ACK;
      ST_ACK: begin
        if (!req) begin
          state_next = ST_IDLE;    // four-phase return to zero
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // outputs decoded from state
  assign load   = (state == ST_IDLE) && req;
  assign step   = (state == ST_RUN);
  assign finish = (state == ST_FIX);
  assign ack    = (state == ST_ACK);

endmodule

// File: src/muldiv_datapath.sv
module muldiv_datapath
  ( input  logic                 clk
  , input  logic                 rst_n
  , input  ex_pipe_pkg::md_req_t operands
  , input  logic                 load
  , input  logic                 step
  , input  logic                 finish
  , output rv_isa_pkg::data_t    result
  );

  import rv_isa_pkg::*;
  import ex_pipe_pkg::*;

  muldiv_op_e  op_q;
  logic        neg_q;              // negate product or quotient
  logic        neg_r;              // negate remainder, follows dividend
  logic [63:0] acc;                // {hi, lo} or {remainder, quotient}
  data_t       mag_b_q;            // multiplicand or divisor
  logic        a_neg;
  logic        b_neg;
  data_t       mag_a;
  data_t       mag_b;
  logic [32:0] mul_sum;
  logic [33:0] div_diff;
  logic [63:0] acc_next;
  logic [63:0] prod;
  data_t       fixed;

  //////////////////////////////
  // operand magnitudes
  //////////////////////////////

  always_comb begin
    a_neg = operands.a[31] && (operands.op inside {MD_MULH, MD_MULHSU, MD_DIV, MD_REM});
    b_neg = operands.b[31] && (operands.op inside {MD_MULH, MD_DIV, MD_REM});
    mag_a = a_neg ? -operands.a : operands.a;
    mag_b = b_neg ? -operands.b : operands.b;
  end

  // one shift-add or restoring step
  always_comb begin
    mul_sum  = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, mag_b_q} : 33'd0);
    div_diff = {1'b0, acc[63:31]} - {2'b00, mag_b_q};
    if (op_q inside {MD_DIV, MD_DIVU, MD_REM, MD_REMU}) begin
      acc_next = div_diff[33] ? {acc[62:0], 1'b0}
                              : {div_diff[31:0], acc[30:0], 1'b1};
    end else begin
      acc_next = {mul_sum, acc[31:1]};
    end
  end

  // divide by zero ends with all-ones quotient and |a| as remainder
  always_comb begin
    prod = neg_q ? -acc : acc;
    case (op_q)
      MD_MUL:                       fixed = prod[31:0];
      MD_MULH, MD_MULHSU, MD_MULHU: fixed = prod[63:32];
      MD_DIV, MD_DIVU:              fixed = neg_q ? -acc[31:0] : acc[31:0];
      default:                      fixed = neg_r ? -acc[63:32] : acc[63:32];
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_q  <= MD_MUL;
      neg_q <= 1'b0;
      neg_r <= 1'b0;
    end else if (load) begin
      op_q  <= operands.op;
      neg_q <= (a_neg ^ b_neg) && (operands.b != '0);   // no sign flip on /0
      neg_r <= a_neg;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      acc     <= {32'd0, mag_a};
      mag_b_q <= mag_b;
    end else if (step) begin
      acc <= acc_next;
    end
    if (finish) begin
      result <= fixed;
    end
  end

endmodule

// File: src/execute.sv
module execute
  ( input  logic                    clk
  , input  logic                    rst_n
  , input  ex_pipe_pkg::id_to_ex_t  id_to_ex
  , input  ex_pipe_pkg::fwd_sel_e   fwd_a
  , input  ex_pipe_pkg::fwd_sel_e   fwd_b
  , input  ex_pipe_pkg::fwd_src_t   mem_fwd
  , input  ex_pipe_pkg::fwd_src_t   wb_fwd
  , input  logic                    md_ack
  , input  rv_isa_pkg::data_t       md_result
  , output logic                    md_req
  , output ex_pipe_pkg::md_req_t    md_operands
  , output ex_pipe_pkg::ex_to_mem_t ex_to_mem
  , output ex_pipe_pkg::ex_to_if_t  ex_to_if
  , output logic                    stall
  );

  import rv_isa_pkg::*;
  import ex_pipe_pkg::*;

  data_t alu_a;
  data_t rs2_val;
  data_t alu_b;
  data_t alu_result;
  logic  alu_zero;
  logic  take;
  logic  md_done;
  logic  md_launch;
  logic  complete;

  //////////////////////////////
  // operand select
  //////////////////////////////

  always_comb begin
    case (fwd_a)
      FWD_REG: alu_a = id_to_ex.rd1;
      FWD_MEM: alu_a = mem_fwd.value;
      FWD_WB:  alu_a = wb_fwd.value;
      default: alu_a = 'x;
    endcase
  end

  always_comb begin
    case (fwd_b)
      FWD_REG: rs2_val = id_to_ex.rd2;
      FWD_MEM: rs2_val = mem_fwd.value;
      FWD_WB:  rs2_val = wb_fwd.value;
      default: rs2_val = 'x;
    endcase
  end

  assign alu_b = (id_to_ex.alu_src_b == SRC_B_IMM) ? id_to_ex.imm_ext : rs2_val;

  alu u_alu
    ( .a      ( alu_a           )
    , .b      ( alu_b           )
    , .op     ( id_to_ex.alu_op )
    , .result ( alu_result      )
    , .zero   ( alu_zero        )
    );

  // decode picked sub for eq/ne and slt/sltu for the ordered compares
  always_comb begin
    case (id_to_ex.funct3)
      F3_BEQ, F3_BGE, F3_BGEU: take = alu_zero;
      F3_BNE, F3_BLT, F3_BLTU: take = !alu_zero;
      default:                 take = 1'b0;
    endcase
  end

  always_comb begin
    ex_to_if.redirect = id_to_ex.valid && !id_to_ex.is_muldiv
                        && (id_to_ex.jump || (id_to_ex.branch && take));
    ex_to_if.target   = id_to_ex.jalr ? {alu_result[31:1], 1'b0}
                                      : id_to_ex.pc_cur + id_to_ex.imm_ext;
  end

  //////////////////////////////
  // muldiv handshake
  //////////////////////////////

  assign md_done   = md_req && md_ack;                 // result present this cycle
  assign md_launch = id_to_ex.valid && id_to_ex.is_muldiv && !md_req && !md_ack;
  assign stall     = id_to_ex.valid && id_to_ex.is_muldiv && !md_done;
  assign complete  = id_to_ex.valid && (!id_to_ex.is_muldiv || md_done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      md_req <= 1'b0;
    end else if (md_done) begin
      md_req <= 1'b0;
    end else if (md_launch) begin
      md_req <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (md_launch) begin
      md_operands <= '{op: id_to_ex.md_op, a: alu_a, b: rs2_val};  // held until ack
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_to_mem <= '0;
    end else begin
      ex_to_mem.valid <= complete;
      if (complete) begin
        ex_to_mem.reg_write  <= id_to_ex.reg_write;
        ex_to_mem.result_src <= id_to_ex.result_src;
        ex_to_mem.rd         <= id_to_ex.rd;
        ex_to_mem.result     <= id_to_ex.is_muldiv ? md_result : alu_result;
        ex_to_mem.pc_cur     <= id_to_ex.pc_cur;
      end
    end
  end

endmodule

// File: src/ex_subsystem.sv
module ex_subsystem
  ( input  logic                    clk
  , input  logic                    rst_n
  , input  ex_pipe_pkg::id_to_ex_t  id_to_ex
  , input  ex_pipe_pkg::fwd_src_t   mem_fwd
  , input  ex_pipe_pkg::fwd_src_t   wb_fwd
  , output ex_pipe_pkg::ex_to_mem_t ex_to_mem
  , output ex_pipe_pkg::ex_to_if_t  ex_to_if
  , output logic                    stall
  );

  import rv_isa_pkg::*;
  import ex_pipe_pkg::*;

  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;
  logic     md_req;
  logic     md_ack;
  md_req_t  md_operands;
  data_t    md_result;
  logic     md_load;
  logic     md_step;
  logic     md_finish;
  logic     md_last;

  //////////////////////////////
  // execute and bypass
  //////////////////////////////

  forward_unit u_forward_unit
    ( .rs1     ( id_to_ex.rs1 )
    , .rs2     ( id_to_ex.rs2 )
    , .mem_fwd ( mem_fwd      )
    , .wb_fwd  ( wb_fwd       )
    , .fwd_a   ( fwd_a        )
    , .fwd_b   ( fwd_b        )
    );

  execute u_execute
    ( .clk         ( clk         )
    , .rst_n       ( rst_n       )
    , .id_to_ex    ( id_to_ex    )
    , .fwd_a       ( fwd_a       )
    , .fwd_b       ( fwd_b       )
    , .mem_fwd     ( mem_fwd     )
    , .wb_fwd      ( wb_fwd      )
    , .md_ack      ( md_ack      )
    , .md_result   ( md_result   )
    , .md_req      ( md_req      )
    , .md_operands ( md_operands )
    , .ex_to_mem   ( ex_to_mem   )
    , .ex_to_if    ( ex_to_if    )
    , .stall       ( stall       )
    );

  //////////////////////////////
  // iterative muldiv
  //////////////////////////////

  muldiv_ctrl u_muldiv_ctrl
    ( .clk    ( clk       )
    , .rst_n  ( rst_n     )
    , .req    ( md_req    )
    , .last   ( md_last   )
    , .ack    ( md_ack    )
    , .load   ( md_load   )
    , .step   ( md_step   )
    , .finish ( md_finish )
    );

  step_counter u_step_counter
    ( .clk   ( clk     )
    , .rst_n ( rst_n   )
    , .load  ( md_load )
    , .step  ( md_step )
    , .last  ( md_last )
    );

  muldiv_datapath u_muldiv_datapath
    ( .clk      ( clk         )
    , .rst_n    ( rst_n       )
    , .operands ( md_operands )
    , .load     ( md_load     )
    , .step     ( md_step     )
    , .finish   ( md_finish   )
    , .result   ( md_result   )
    );

endmodule

// File: test/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

//////////////////////////////
// bypass and alu
//////////////////////////////

function automatic data_t operand_value(reg_idx_t rs, data_t reg_val,
                                       fwd_src_t mem, fwd_src_t wb);
  data_t v;
  v = reg_val;
  if (rs != 5'd0 && wb.reg_write && wb.rd == rs) begin
    v = wb.value;
  end
  if (rs != 5'd0 && mem.reg_write && mem.rd == rs) begin
    v = mem.value;                         // memory stage is younger, overrides wb
  end
  return v;
endfunction

function automatic data_t alu_model(data_t a, data_t b, alu_op_e op);
  data_t r;
  case (op)
    ALU_ADD:    r = a + b;
    ALU_SUB:    r = a - b;
    ALU_AND:    r = a & b;
    ALU_OR:     r = a | b;
    ALU_XOR:    r = a ^ b;
    ALU_SLL:    r = a << b[4:0];
    ALU_SRL:    r = a >> b[4:0];
    ALU_SRA:    r = $signed(a) >>> b[4:0];
    ALU_SLT:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    ALU_SLTU:   r = (a < b) ? 32'd1 : 32'd0;
    ALU_PASS_B: r = b;
    default:    r = '0;
  endcase
  return r;
endfunction

// rs1 against rs2 as the isa defines each condition
function automatic logic branch_taken(funct3_t f3, data_t a, data_t b);
  logic t;
  case (f3)
    F3_BEQ:  t = (a == b);
    F3_BNE:  t = (a != b);
    F3_BLT:  t = ($signed(a) < $signed(b));
    F3_BGE:  t = ($signed(a) >= $signed(b));
    F3_BLTU: t = (a < b);
    F3_BGEU: t = (a >= b);
    default: t = 1'b0;
  endcase
  return t;
endfunction

//////////////////////////////
// m extension
//////////////////////////////

function automatic data_t muldiv_model(muldiv_op_e op, data_t a, data_t b);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  logic signed [63:0] p_ss;
  logic signed [63:0] p_su;
  logic signed [63:0] q_s;
  logic signed [63:0] r_s;
  logic [63:0]        p_uu;
  data_t              q_u;
  data_t              r_u;
  data_t              res;
  sa   = $signed({{32{a[31]}}, a});
  sb   = $signed({{32{b[31]}}, b});
  p_ss = sa * sb;
  p_su = sa * $signed({32'd0, b});
  p_uu = {32'd0, a} * {32'd0, b};
  if (b == '0) begin
    q_s = '1;                              // quotient all ones, remainder is the dividend
    r_s = sa;
    q_u = '1;
    r_u = a;
  end else begin
    q_s = sa / sb;                         // 64 bit, so min / -1 lands on 0x8000_0000
    r_s = sa % sb;
    q_u = a / b;
    r_u = a % b;
  end
  case (op)
    MD_MUL:    res = p_ss[31:0];
    MD_MULH:   res = p_ss[63:32];
    MD_MULHSU: res = p_su[63:32];
    MD_MULHU:  res = p_uu[63:32];
    MD_DIV:    res = q_s[31:0];
    MD_DIVU:   res = q_u;
    MD_REM:    res = r_s[31:0];
    default:   res = r_u;
  endcase
  return res;
endfunction

`endif

// File: test/tb_ex_subsystem.sv
module tb_ex_subsystem;

  timeunit 1ns;
  timeprecision 100ps;

  import rv_isa_pkg::*;
  import ex_pipe_pkg::*;

  `include "ex_ref_model.svh"

  localparam int NUM_INSTR  = 300;
  localparam int MAX_CYCLES = NUM_INSTR * 40 + 100;

  typedef struct {
    ex_to_mem_t data;
    logic       is_md;
    int         cycle;                     // negedge count when presented
  } exp_entry_t;

  logic        clk = 1'b0;
  logic        rst_n;
  id_to_ex_t   id_to_ex;
  fwd_src_t    mem_fwd;
  fwd_src_t    wb_fwd;
  ex_to_mem_t  ex_to_mem;
  ex_to_if_t   ex_to_if;
  logic        stall;

  logic [31:0] lfsr = 32'd89702;
  exp_entry_t  exp_q[$];
  logic        exp_redirect;
  addr_t       exp_target;
  logic        advance;
  int          cycle_no;
  int          sent;
  int          cycles = 0;

  ex_subsystem dut
    ( .clk       ( clk       )
    , .rst_n     ( rst_n     )
    , .id_to_ex  ( id_to_ex  )
    , .mem_fwd   ( mem_fwd   )
    , .wb_fwd    ( wb_fwd    )
    , .ex_to_mem ( ex_to_mem )
    , .ex_to_if  ( ex_to_if  )
    , .stall     ( stall     )
    );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      report_error($sformatf("timeout, the run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic report_error(string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      report_error($sformatf("CHECK FAILED at %0t ns: %s got %h expected %h",
                             $time, name, got, exp));
    end
  endtask

  task automatic build_instr();
    id_to_ex_t   ins;
    exp_entry_t  e;
    logic [11:0] imm12;
    data_t       a;
    data_t       rs2v;
    data_t       alu_res;
    ins         = '0;
    imm12       = 12'(rand_bits(12));
    ins.valid   = (rand_bits(4) != 0);     // roughly one bubble in sixteen
    ins.pc_cur  = {30'(rand_bits(30)), 2'b00};
    ins.rd1     = rand_bits(32);
    ins.rd2     = rand_bits(32);
    ins.imm_ext = {{20{imm12[11]}}, imm12};
    ins.rs1     = 5'(rand_bits(2));        // x0..x3 so bypass hits are common
    ins.rs2     = 5'(rand_bits(2));
    ins.rd      = 5'(rand_bits(2));
    ins.reg_write     = 1'b1;
    mem_fwd.reg_write = (rand_bits(1) != 0);
    mem_fwd.rd        = 5'(rand_bits(2));
    mem_fwd.value     = rand_bits(32);
    wb_fwd.reg_write  = (rand_bits(1) != 0);
    wb_fwd.rd         = 5'(rand_bits(2));
    wb_fwd.value      = rand_bits(32);
    case (rand_bits(3))
      0, 1: begin
        ins.is_muldiv = 1'b1;
        ins.jump      = (rand_bits(1) != 0);  // must never redirect
        ins.md_op     = muldiv_op_e'(3'(rand_bits(3)));
        case (rand_bits(3))
          0: begin                         // divide by zero
            ins.rs2 = '0;
            ins.rd2 = '0;
          end
          1: begin                         // most negative by minus one
            ins.rs1 = '0;
            ins.rs2 = '0;
            ins.rd1 = 32'h8000_0000;
            ins.rd2 = '1;
          end
          2: begin
            ins.rs2 = '0;
            ins.rd2 = rand_bits(6);        // small divisor, non trivial quotient
          end
          default: ;
        endcase
      end
      2: begin
        ins.branch    = 1'b1;
        ins.reg_write = 1'b0;
        case (rand_bits(3) % 6)
          0: ins.funct3 = F3_BEQ;
          1: ins.funct3 = F3_BNE;
          2: ins.funct3 = F3_BLT;
          3: ins.funct3 = F3_BGE;
          4: ins.funct3 = F3_BLTU;
          default: ins.funct3 = F3_BGEU;
        endcase
        ins.alu_op = !ins.funct3[2] ? ALU_SUB : (!ins.funct3[1] ? ALU_SLT : ALU_SLTU);
      end
      3: begin
        ins.jump       = 1'b1;
        ins.jalr       = (rand_bits(1) != 0);
        ins.alu_op     = ALU_ADD;
        ins.alu_src_b  = SRC_B_IMM;
        ins.result_src = RES_PC4;
      end
      default: begin
        ins.alu_op    = alu_op_e'(4'(rand_bits(4) % 11));
        ins.alu_src_b = alu_src_b_e'(1'(rand_bits(1)));
      end
    endcase
    a       = operand_value(ins.rs1, ins.rd1, mem_fwd, wb_fwd);
    rs2v    = operand_value(ins.rs2, ins.rd2, mem_fwd, wb_fwd);
    alu_res = alu_model(a, (ins.alu_src_b == SRC_B_IMM) ? ins.imm_ext : rs2v, ins.alu_op);
    exp_redirect = ins.valid && !ins.is_muldiv
                   && (ins.jump || (ins.branch && branch_taken(ins.funct3, a, rs2v)));
    exp_target   = ins.jalr ? {alu_res[31:1], 1'b0} : ins.pc_cur + ins.imm_ext;
    if (ins.valid) begin
      e.data            = '0;
      e.data.valid      = 1'b1;
      e.data.reg_write  = ins.reg_write;
      e.data.result_src = ins.result_src;
      e.data.rd         = ins.rd;
      e.data.result     = ins.is_muldiv ? muldiv_model(ins.md_op, a, rs2v) : alu_res;
      e.data.pc_cur     = ins.pc_cur;
      e.is_md           = ins.is_muldiv;
      e.cycle           = cycle_no;
      exp_q.push_back(e);
    end
    id_to_ex = ins;
  endtask

  task automatic check_output();
    exp_entry_t e;
    int         lat;
    if (ex_to_mem.valid) begin
      assert (exp_q.size() != 0) else begin
        report_error("ex_to_mem.valid was set with no instruction outstanding");
      end
      e   = exp_q.pop_front();
      lat = cycle_no - e.cycle;
      check_value("ex_to_mem.reg_write", ex_to_mem.reg_write, e.data.reg_write);
      check_value("ex_to_mem.result_src", ex_to_mem.result_src, e.data.result_src);
      check_value("ex_to_mem.rd", ex_to_mem.rd, e.data.rd);
      check_value("ex_to_mem.result", ex_to_mem.result, e.data.result);
      check_value("ex_to_mem.pc_cur", ex_to_mem.pc_cur, e.data.pc_cur);
      assert (e.is_md ? (lat >= 35 && lat <= 37) : (lat == 1)) else begin
        report_error($sformatf("result arrived %0d cycles after its instruction", lat));
      end
    end else if (exp_q.size() != 0) begin
      lat = cycle_no - exp_q[0].cycle;
      assert (lat < (exp_q[0].is_md ? 37 : 1)) else begin
        report_error($sformatf("no result on ex_to_mem %0d cycles after the instruction", lat));
      end
    end
  endtask

  // combinational outputs, sampled mid cycle
  task automatic check_comb();
    if (!(id_to_ex.valid && id_to_ex.is_muldiv)) begin
      check_value("stall", stall, 1'b0);
    end else if (cycle_no - exp_q[$].cycle < 34) begin
      check_value("stall", stall, 1'b1);   // no result can be ready yet
    end
    check_value("ex_to_if.redirect", ex_to_if.redirect, exp_redirect);
    if (id_to_ex.valid) begin
      check_value("ex_to_if.target", ex_to_if.target, exp_target);
    end
    advance = !stall;                      // upstream holds while stalled
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    rst_n        = 1'b0;
    id_to_ex     = '0;
    mem_fwd      = '0;
    wb_fwd       = '0;
    exp_redirect = 1'b0;
    exp_target   = '0;
    advance      = 1'b1;
    cycle_no     = 0;
    sent         = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value("ex_to_mem.valid", ex_to_mem.valid, 1'b0);
    check_value("stall", stall, 1'b0);
    rst_n = 1'b1;
    while (sent < NUM_INSTR || exp_q.size() != 0) begin
      @(negedge clk);
      cycle_no++;
      check_output();
      if (advance && sent < NUM_INSTR) begin
        build_instr();
        sent++;
      end else if (advance) begin
        id_to_ex.valid = 1'b0;             // drain with bubbles
        exp_redirect   = 1'b0;
      end
      #1;
      check_comb();
    end
    repeat (4) begin                       // nothing may follow the last result
      @(negedge clk);
      cycle_no++;
      check_output();
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+test
src/pkg/rv_isa_pkg.sv
src/pkg/ex_pipe_pkg.sv
src/alu.sv
src/forward_unit.sv
src/step_counter.sv
src/muldiv_ctrl.sv
src/muldiv_datapath.sv
src/execute.sv
src/ex_subsystem.sv
test/tb_ex_subsystem.sv

// File: Bender.yml
package:
  name: ex_subsystem

sources:
  - files:
      - src/pkg/rv_isa_pkg.sv
      - src/pkg/ex_pipe_pkg.sv
      - src/alu.sv
      - src/forward_unit.sv
      - src/step_counter.sv
      - src/muldiv_ctrl.sv
      - src/muldiv_datapath.sv
      - src/execute.sv
      - src/ex_subsystem.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_ex_subsystem.sv
